// File: dp_consts.svh
`ifndef DP_CONSTS_SVH
`define DP_CONSTS_SVH

// datapath sizes
`define WORD_W       32
`define REG_COUNT    16
`define SHAMT_W      5      // low bits of b used as shift count

// instruction field widths, msb first: opcode, ra, rb, then rc or c2
`define OPCODE_W     5
`define REG_FIELD_W  4
`define RC_PAD_W     15     // unused tail of the register form
`define C2_W         19     // immediate constant

// alu operation codes
`define ALU_OP_W     4
`define ALU_ADD      4'd0
`define ALU_SUB      4'd1
`define ALU_AND      4'd2
`define ALU_OR       4'd3
`define ALU_SHR      4'd4   // logical
`define ALU_SHL      4'd5
`define ALU_ROR      4'd6
`define ALU_ROL      4'd7
`define ALU_NEG      4'd8
`define ALU_NOT      4'd9
`define ALU_MUL      4'd10

`endif

// File: dpPkg.sv
`default_nettype none
`include "dp_consts.svh"

package dpPkg;

    typedef logic [`ALU_OP_W-1:0] aluOpT;

    // one cycle of strobes, 24 bits
    typedef struct packed {
        logic  pcOut;       // bus drivers, one-hot or none
        logic  zLowOut;
        logic  zHighOut;
        logic  mdrOut;
        logic  cSignOut;
        logic  rOut;
        logic  baOut;
        logic  gra;         // register field selects
        logic  grb;
        logic  grc;
        logic  rIn;         // register loads
        logic  marIn;
        logic  mdrIn;
        logic  irIn;
        logic  yIn;
        logic  pcIn;
        logic  zIn;
        logic  incPc;
        logic  read;
        logic  write;
        aluOpT aluOp;
    } controlWord;

    typedef struct packed {
        logic [`OPCODE_W-1:0]    opcode;
        logic [`REG_FIELD_W-1:0] ra;
        logic [`REG_FIELD_W-1:0] rb;
        logic [`REG_FIELD_W-1:0] rc;
        logic [`RC_PAD_W-1:0]    unused;
    } regFormT;

    typedef struct packed {
        logic [`OPCODE_W-1:0]    opcode;
        logic [`REG_FIELD_W-1:0] ra;
        logic [`REG_FIELD_W-1:0] rb;
        logic [`C2_W-1:0]        c2;
    } immFormT;

    // regFile reads the register view, cpuRegs the immediate view
    typedef union packed {
        regFormT regForm;
        immFormT immForm;
    } instrWord;

endpackage

`default_nettype wire

// File: regFile.sv
`timescale 1ns/10ps
`default_nettype none
`include "dp_consts.svh"

module regFile (
    input  logic               clock,
    input  logic               rstN,
    input  dpPkg::controlWord  ctrl,
    input  dpPkg::instrWord    instr,
    input  logic [`WORD_W-1:0] bus,
    output logic [`WORD_W-1:0] regValue
);

    logic [`WORD_W-1:0]      registers [`REG_COUNT];
    logic [`REG_FIELD_W-1:0] selIndex;
    logic                    selValid;     // one of gra/grb/grc is set
    logic [`REG_COUNT-1:0]   regSelect;    // one-hot
    logic [`WORD_W-1:0]      selValue;

    // pick the instruction field named by the strobes
    always_comb begin
        selIndex = '0;
        selValid = 1'b1;
        if (ctrl.gra) begin
            selIndex = instr.regForm.ra;
        end else if (ctrl.grb) begin
            selIndex = instr.regForm.rb;
        end else if (ctrl.grc) begin
            selIndex = instr.regForm.rc;
        end else begin
            selValid = 1'b0;
        end
    end

    always_comb begin
        regSelect = '0;
        if (selValid) begin
            regSelect[selIndex] = 1'b1;
        end
    end

    // and-or read through the one-hot select
    always_comb begin
        selValue = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            if (regSelect[i]) begin
                selValue = selValue | registers[i];
            end
        end
    end

    // base-address read of r0 gives zero, as for an absolute address
    always_comb begin
        if (ctrl.baOut && regSelect[0]) begin
            regValue = '0;
        end else if (ctrl.rOut || ctrl.baOut) begin
            regValue = selValue;
        end else begin
            regValue = '0;
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (ctrl.rIn) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                if (regSelect[i]) begin
                    registers[i] <= bus;       // no write when nothing selected
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/10ps
`default_nettype none
`include "dp_consts.svh"

module alu (
    input  logic [`WORD_W-1:0]   a,            // from Y
    input  logic [`WORD_W-1:0]   b,            // from the bus
    input  dpPkg::aluOpT         op,
    output logic [2*`WORD_W-1:0] result
);

    logic [`SHAMT_W-1:0]   shamt;
    logic [2*`WORD_W-1:0]  aDouble;
    logic [2*`WORD_W-1:0]  rorWide;
    logic [2*`WORD_W-1:0]  rolWide;
    logic [2*`WORD_W-1:0]  product;
    logic [`WORD_W-1:0]    low;

    assign shamt   = b[`SHAMT_W-1:0];
    assign aDouble = {a, a};                   // rotate by shifting two copies
    assign rorWide = aDouble >> shamt;
    assign rolWide = aDouble << shamt;

    // low 64 bits of the sign-extended product equal the signed product
    assign product = {{`WORD_W{a[`WORD_W-1]}}, a} * {{`WORD_W{b[`WORD_W-1]}}, b};

    always_comb begin
        case (op)
            `ALU_ADD: low = a + b;
            `ALU_SUB: low = a - b;
            `ALU_AND: low = a & b;
            `ALU_OR:  low = a | b;
            `ALU_SHR: low = a >> shamt;
            `ALU_SHL: low = a << shamt;
            `ALU_ROR: low = rorWide[`WORD_W-1:0];
            `ALU_ROL: low = rolWide[2*`WORD_W-1:`WORD_W];
            `ALU_NEG: low = -b;                 // unary ops work on the bus operand
            `ALU_NOT: low = ~b;
            `ALU_MUL: low = product[`WORD_W-1:0];
            default:  low = '0;
        endcase
    end

    // every op but multiply sign-fills the high half
    always_comb begin
        if (op == `ALU_MUL) begin
            result = product;
        end else begin
            result = {{`WORD_W{low[`WORD_W-1]}}, low};
        end
    end

endmodule

`default_nettype wire

// File: cpuRegs.sv
`timescale 1ns/10ps
`default_nettype none
`include "dp_consts.svh"

module cpuRegs (
    input  logic                 clock,
    input  logic                 rstN,
    input  dpPkg::controlWord    ctrl,
    input  logic [`WORD_W-1:0]   regValue,
    input  logic [`WORD_W-1:0]   mdrValue,
    input  logic [2*`WORD_W-1:0] aluResult,
    output logic [`WORD_W-1:0]   bus,
    output logic [`WORD_W-1:0]   yValue,
    output dpPkg::instrWord      instr
);

    import dpPkg::*;

    logic [`WORD_W-1:0]   pcReg;
    instrWord             irReg;
    logic [`WORD_W-1:0]   yReg;
    logic [2*`WORD_W-1:0] zReg;
    logic [2*`WORD_W-1:0] zNext;
    logic [`WORD_W-1:0]   cSignExt;

    assign instr  = irReg;
    assign yValue = yReg;

    // c2 sign-extended to a full word
    assign cSignExt = {{(`WORD_W-`C2_W){irReg.immForm.c2[`C2_W-1]}}, irReg.immForm.c2};

    // PC increment goes through Z, so the next cycle can move it back to the PC
    always_comb begin
        if (ctrl.incPc) begin
            zNext = {{`WORD_W{1'b0}}, pcReg + `WORD_W'(1)};
        end else begin
            zNext = aluResult;
        end
    end

    // single bus, fixed priority if more than one driver is set
    always_comb begin
        if (ctrl.rOut || ctrl.baOut) begin
            bus = regValue;
        end else if (ctrl.mdrOut) begin
            bus = mdrValue;
        end else if (ctrl.zLowOut) begin
            bus = zReg[`WORD_W-1:0];
        end else if (ctrl.zHighOut) begin
            bus = zReg[2*`WORD_W-1:`WORD_W];
        end else if (ctrl.pcOut) begin
            bus = pcReg;
        end else if (ctrl.cSignOut) begin
            bus = cSignExt;
        end else begin
            bus = '0;                           // idle bus
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pcReg <= '0;
            irReg <= '0;
            yReg  <= '0;
            zReg  <= '0;
        end else begin
            if (ctrl.pcIn) begin
                pcReg <= bus;
            end
            if (ctrl.irIn) begin
                irReg <= bus;
            end
            if (ctrl.yIn) begin
                yReg <= bus;
            end
            if (ctrl.zIn) begin
                zReg <= zNext;
            end
        end
    end

endmodule

`default_nettype wire

// File: memPort.sv
`timescale 1ns/10ps
`default_nettype none
`include "dp_consts.svh"

module memPort (
    input  logic               clock,
    input  logic               rstN,
    input  dpPkg::controlWord  ctrl,
    input  logic [`WORD_W-1:0] bus,
    input  logic [`WORD_W-1:0] memData,        // combinational read data
    output logic [`WORD_W-1:0] memAddr,
    output logic [`WORD_W-1:0] memWriteData,
    output logic [`WORD_W-1:0] mdrValue,
    output logic               memWrite
);

    logic [`WORD_W-1:0] marReg;
    logic [`WORD_W-1:0] mdrReg;
    logic [`WORD_W-1:0] mdrNext;

    // read selects memory over the bus
    assign mdrNext = ctrl.read ? memData : bus;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            marReg <= '0;
            mdrReg <= '0;
        end else begin
            if (ctrl.marIn) begin
                marReg <= bus;
            end
            if (ctrl.mdrIn) begin
                mdrReg <= mdrNext;
            end
        end
    end

    assign memAddr      = marReg;
    assign memWriteData = mdrReg;
    assign mdrValue     = mdrReg;
    assign memWrite     = ctrl.write;           // same cycle as the strobe

endmodule

`default_nettype wire

// File: dataPath.sv
`timescale 1ns/10ps
`default_nettype none
`include "dp_consts.svh"

module dataPath (
    input  logic               clock,
    input  logic               rstN,
    input  dpPkg::controlWord  ctrl,
    input  logic [`WORD_W-1:0] memData,
    output logic [`WORD_W-1:0] memAddr,
    output logic [`WORD_W-1:0] memWriteData,
    output logic               memWrite,
    output logic [`WORD_W-1:0] busValue        // debug view of the bus
);

    import dpPkg::*;

    logic [`WORD_W-1:0]   bus;
    logic [`WORD_W-1:0]   regValue;
    logic [`WORD_W-1:0]   mdrValue;
    logic [`WORD_W-1:0]   yValue;
    logic [2*`WORD_W-1:0] aluResult;
    instrWord             instr;

    regFile uRegFile (
        .clock    (clock),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .instr    (instr),
        .bus      (bus),
        .regValue (regValue)
    );

    alu uAlu (
        .a      (yValue),
        .b      (bus),
        .op     (ctrl.aluOp),
        .result (aluResult)
    );

    cpuRegs uCpuRegs (
        .clock     (clock),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .regValue  (regValue),
        .mdrValue  (mdrValue),
        .aluResult (aluResult),
        .bus       (bus),
        .yValue    (yValue),
        .instr     (instr)
    );

    memPort uMemPort (
        .clock        (clock),
        .rstN         (rstN),
        .ctrl         (ctrl),
        .bus          (bus),
        .memData      (memData),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .mdrValue     (mdrValue),
        .memWrite     (memWrite)
    );

    assign busValue = bus;

endmodule

`default_nettype wire

// File: tb_dataPath.sv
`timescale 1ns/10ps
`default_nettype none
`include "dp_consts.svh"

module tb_dataPath;

    import dpPkg::*;

    typedef struct {
        controlWord         ctrl;
        bit                 checkBus;
        logic [`WORD_W-1:0] expBus;
        bit                 checkMem;
        logic [7:0]         memIndex;
        logic [`WORD_W-1:0] memVal;
    } rowT;

    logic               clock;
    logic               rstN;
    controlWord         ctrl;
    logic [`WORD_W-1:0] memData;
    logic [`WORD_W-1:0] memAddr;
    logic [`WORD_W-1:0] memWriteData;
    logic               memWrite;
    logic [`WORD_W-1:0] busValue;

    logic [`WORD_W-1:0] mem    [256];      // memory seen by the DUT
    logic [`WORD_W-1:0] expMem [256];      // expected memory contents
    logic [`WORD_W-1:0] mRegs  [`REG_COUNT];
    logic [`WORD_W-1:0] mPc;
    rowT                rows [$];
    integer             seed = 38993;
    integer             errors = 0;
    bit                 tableReady = 0;

    dataPath i_dut (
        .clock        (clock),
        .rstN         (rstN),
        .ctrl         (ctrl),
        .memData      (memData),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWrite     (memWrite),
        .busValue     (busValue)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    // combinational read and a write on the clock edge
    assign memData = mem[memAddr[7:0]];
    always @(posedge clock) begin
        if (memWrite) begin
            mem[memAddr[7:0]] <= memWriteData;
        end
    end

    task automatic checkValue(input string name, input logic [`WORD_W-1:0] got,
                              input logic [`WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [63:0] aluModel(input logic [3:0] op,
                                             input logic [31:0] a, input logic [31:0] b);
        logic [4:0]         s;
        logic [31:0]        r;
        logic signed [63:0] pa;
        logic signed [63:0] pb;
        s  = b[4:0];
        pa = 64'($signed(a));
        pb = 64'($signed(b));
        r  = '0;
        case (op)
            `ALU_ADD: r = a + b;
            `ALU_SUB: r = a - b;
            `ALU_AND: r = a & b;
            `ALU_OR:  r = a | b;
            `ALU_SHR: r = a >> s;
            `ALU_SHL: r = a << s;
            `ALU_ROR: r = (s == 0) ? a : ((a >> s) | (a << (32 - s)));
            `ALU_ROL: r = (s == 0) ? a : ((a << s) | (a >> (32 - s)));
            `ALU_NEG: r = 32'd0 - b;
            `ALU_NOT: r = ~b;
            default:  r = '0;
        endcase
        if (op == `ALU_MUL) begin
            return pa * pb;
        end
        return {{32{r[31]}}, r};
    endfunction

    task automatic addRow(input controlWord c, input bit chkBus, input logic [31:0] expBus,
                          input bit chkMem, input logic [7:0] idx, input logic [31:0] val);
        rowT r;
        r.ctrl     = c;
        r.checkBus = chkBus;
        r.expBus   = expBus;
        r.checkMem = chkMem;
        r.memIndex = idx;
        r.memVal   = val;
        rows.push_back(r);
    endtask

    // T0..T2 with the instruction word placed in memory at the model PC
    task automatic fetchSteps(input logic [31:0] word);
        controlWord c;
        expMem[mPc[7:0]] = word;
        c = '{pcOut: 1'b1, marIn: 1'b1, incPc: 1'b1, zIn: 1'b1, default: '0};
        addRow(c, 1, mPc, 0, 0, 0);
        c = '{zLowOut: 1'b1, pcIn: 1'b1, read: 1'b1, mdrIn: 1'b1, default: '0};
        addRow(c, 1, mPc + 1, 0, 0, 0);
        mPc = mPc + 1;
        c = '{mdrOut: 1'b1, irIn: 1'b1, default: '0};
        addRow(c, 1, word, 0, 0, 0);
    endtask

    // ld ra, c2(r0)
    task automatic loadSteps(input logic [3:0] ra, input logic [18:0] c2);
        controlWord  c;
        logic [31:0] addr;
        addr = {{13{c2[18]}}, c2};
        fetchSteps({5'd1, ra, 4'd0, c2});
        c = '{grb: 1'b1, baOut: 1'b1, yIn: 1'b1, default: '0};
        addRow(c, 1, 32'd0, 0, 0, 0);
        c = '{cSignOut: 1'b1, aluOp: `ALU_ADD, zIn: 1'b1, default: '0};
        addRow(c, 1, addr, 0, 0, 0);
        c = '{zLowOut: 1'b1, marIn: 1'b1, default: '0};
        addRow(c, 1, addr, 0, 0, 0);
        c = '{read: 1'b1, mdrIn: 1'b1, default: '0};
        addRow(c, 1, 32'd0, 0, 0, 0);
        mRegs[ra] = expMem[addr[7:0]];
        c = '{mdrOut: 1'b1, gra: 1'b1, rIn: 1'b1, default: '0};
        addRow(c, 1, mRegs[ra], 0, 0, 0);
    endtask

    // ra = rb op rc plus a zHighOut row for multiply
    task automatic aluSteps(input logic [3:0] op, input logic [3:0] ra,
                            input logic [3:0] rb, input logic [3:0] rc);
        controlWord  c;
        logic [63:0] res;
        res = aluModel(op, mRegs[rb], mRegs[rc]);
        fetchSteps({5'd4, ra, rb, rc, 15'd0});
        c = '{grb: 1'b1, rOut: 1'b1, yIn: 1'b1, default: '0};
        addRow(c, 1, mRegs[rb], 0, 0, 0);
        c = '{grc: 1'b1, rOut: 1'b1, aluOp: op, zIn: 1'b1, default: '0};
        addRow(c, 1, mRegs[rc], 0, 0, 0);
        c = '{zLowOut: 1'b1, gra: 1'b1, rIn: 1'b1, default: '0};
        addRow(c, 1, res[31:0], 0, 0, 0);
        mRegs[ra] = res[31:0];
        if (op == `ALU_MUL) begin
            c = '{zHighOut: 1'b1, default: '0};
            addRow(c, 1, res[63:32], 0, 0, 0);
        end
    endtask

    // st ra, c2(r0) and an idle row that checks the memory word
    task automatic storeSteps(input logic [3:0] ra, input logic [18:0] c2);
        controlWord  c;
        logic [31:0] addr;
        addr = {{13{c2[18]}}, c2};
        fetchSteps({5'd2, ra, 4'd0, c2});
        c = '{grb: 1'b1, baOut: 1'b1, yIn: 1'b1, default: '0};
        addRow(c, 1, 32'd0, 0, 0, 0);
        c = '{cSignOut: 1'b1, aluOp: `ALU_ADD, zIn: 1'b1, default: '0};
        addRow(c, 1, addr, 0, 0, 0);
        c = '{zLowOut: 1'b1, marIn: 1'b1, default: '0};
        addRow(c, 1, addr, 0, 0, 0);
        c = '{gra: 1'b1, rOut: 1'b1, mdrIn: 1'b1, default: '0};
        addRow(c, 1, mRegs[ra], 0, 0, 0);
        c = '{write: 1'b1, default: '0};
        addRow(c, 1, 32'd0, 0, 0, 0);
        expMem[addr[7:0]] = mRegs[ra];
        c = '0;
        addRow(c, 1, 32'd0, 1, addr[7:0], mRegs[ra]);
    endtask

    task automatic buildTable();
        logic [3:0] ops [10];
        ops = '{`ALU_ADD, `ALU_SUB, `ALU_AND, `ALU_OR, `ALU_SHL,
                `ALU_SHR, `ALU_ROL, `ALU_ROR, `ALU_NEG, `ALU_NOT};
        for (int i = 0; i < 256; i++) begin
            expMem[i] = $random(seed);              // operand fill over every word
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            mRegs[i] = '0;
        end
        mPc = '0;
        loadSteps(4'd0, 19'd129);                   // r0 holds a nonzero word under baOut
        loadSteps(4'd1, 19'd130);
        loadSteps(4'd2, 19'd131);
        for (int i = 0; i < 10; i++) begin
            aluSteps(ops[i], 4'(5 + i), 4'd1, 4'd2);
        end
        aluSteps(`ALU_MUL, 4'd3, 4'd1, 4'd2);
        storeSteps(4'd5, 19'd200);
        for (int i = 0; i < 256; i++) begin
            mem[i] = expMem[i];
        end
        mem[200] = ~expMem[200];                    // so the store must change it
    endtask

    initial begin
        rstN = 1'b0;
        ctrl = '0;
        buildTable();
        tableReady = 1;
        repeat (5) @(posedge clock);
        #2;
        rstN = 1'b1;
        #5;
        checkValue("busValue", busValue, '0);
        checkValue("memWrite", `WORD_W'(memWrite), '0);
        foreach (rows[i]) begin
            @(posedge clock);
            #2;
            ctrl = rows[i].ctrl;
            #10;
            if (rows[i].checkBus) begin
                checkValue("busValue", busValue, rows[i].expBus);
            end
            checkValue("memWrite", `WORD_W'(memWrite), `WORD_W'(rows[i].ctrl.write));
            if (rows[i].checkMem) begin
                checkValue("mem", mem[rows[i].memIndex], rows[i].memVal);
            end
        end
        @(posedge clock);
        #2;
        ctrl = '0;
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (tableReady);
        #((rows.size() + 5 + 20) * 40);
        $display("Timeout: the run did not reach its end in time");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
dpPkg.sv
regFile.sv
alu.sv
cpuRegs.sv
memPort.sv
dataPath.sv
tb_dataPath.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= tb_dataPath
RTL_TOP   ?= dataPath
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(shell cat $(FILELIST) | grep -v '^+') dp_consts.svh
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "All tests passed" $(LOG) || { echo "simulation failed"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
